// File: tb.f
board_pkg.sv
slow_tick_gen.sv
display_scan.sv
lab_core.sv
hex_sticky_latch.sv
mic_i2s_receiver.sv
board_top.sv
board_top_asserts.sv
tb_board_top.sv

// File: Bender.yml
package:
  name: board_top

sources:
  - board_pkg.sv
  - slow_tick_gen.sv
  - display_scan.sv
  - lab_core.sv
  - hex_sticky_latch.sv
  - mic_i2s_receiver.sv
  - board_top.sv
  - target: simulation
    files:
      - board_top_asserts.sv
      - tb_board_top.sv

// File: tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

    localparam int clk_period    = 20;
    localparam int frame_cycles  = board_pkg::w_digit * board_pkg::scan_cycles;   // One scan pass
    localparam int settle_cycles = 2 * board_pkg::sck_half_cycles + 4;          // Capture latency
    localparam int i2s_frame     = 4 * board_pkg::sck_half_cycles * board_pkg::mic_bits_per_half;
    localparam int n_pulses      = 6;
    localparam int n_mic_frames  = 8;
    localparam int n_toggles     = 4;
    localparam int test_cycles   = 200 + 13 * board_pkg::slow_tick_cycles
                                 + n_pulses * (frame_cycles + settle_cycles + 10)
                                 + (n_mic_frames + 1 + n_toggles)
                                 * (i2s_frame + frame_cycles + settle_cycles + 20);
    localparam int watchdog_ns   = test_cycles * clk_period * 12 / 10;  // 20 percent margin

    // Active-high abcdefgh patterns for 0..F
    localparam board_pkg::seg_t seg_table [16] = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6,
        8'hbe, 8'he0, 8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};

    logic                          clk;
    logic                          rst;
    logic [board_pkg::w_key - 1:0] key_n;
    logic [board_pkg::w_sw  - 1:0] sw;
    logic [board_pkg::w_led - 1:0] led;
    board_pkg::seg_t               hex0, hex1, hex2, hex3, hex4, hex5;
    logic                          mic_lr, mic_ws, mic_sck;
    logic                          mic_sd = 1'b0;

    board_pkg::seg_t   hex_all [board_pkg::w_digit];  // Displays by index
    logic [31:0]       lfsr = 32'h2e29;
    board_pkg::count_t model_cnt;                     // Expected counter
    int                edge_n;                        // Clock edges since reset
    int                model_ticks;                   // Slow ticks seen by the model
    logic              tick_due;
    board_pkg::mic_t   mic_words [$];                 // Words sent by the microphone
    board_pkg::mic_t   mic_word;
    int                mic_bit = board_pkg::w_mic;    // Idle until the first frame
    logic              ws_prev = 1'b0;

    board_top dut
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key_n   ( key_n   ),
        .sw      ( sw      ),
        .led     ( led     ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .hex4    ( hex4    ),
        .hex5    ( hex5    ),
        .mic_lr  ( mic_lr  ),
        .mic_ws  ( mic_ws  ),
        .mic_sck ( mic_sck ),
        .mic_sd  ( mic_sd  )
    );

    assign hex_all [0] = hex0;
    assign hex_all [1] = hex1;
    assign hex_all [2] = hex2;
    assign hex_all [3] = hex3;
    assign hex_all [4] = hex4;
    assign hex_all [5] = hex5;

    initial
        clk = 1'b0;

    always #(clk_period / 2) clk = ~ clk;

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------

    function automatic logic [31:0] lfsr_step (input logic [31:0] s);
        return { s [30:0], s [31] ^ s [21] ^ s [1] ^ s [0] };  // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] random_bits (input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step (lfsr);    // One step per bit
            r    = { r [30:0], lfsr [0] };
        end
        return r;
    endfunction

    // Scanned pattern as a static display sees it
    function automatic board_pkg::seg_t static_image (input logic [3:0] nibble);
        board_pkg::seg_t s;
        board_pkg::seg_t r;
        s = seg_table [nibble];
        for (int i = 0; i < 8; i++)
            r [i] = ~ s [7 - i];       // Active low with segment a on bit 0
        return r;
    endfunction

    task automatic abort_run ();
        $display ("Test failed");
        $fatal (1, "Stopped at the first error");
    endtask

    task automatic check_led ();
        assert (led === model_cnt [board_pkg::w_led - 1:0])
        else
        begin
            $display ("Mismatch led: got %h, expected %h", led,
                      model_cnt [board_pkg::w_led - 1:0]);
            abort_run ();
        end
    endtask

    // Waits the given clocks and then compares all six displays
    task automatic check_display (input board_pkg::count_t value, input int cycles);
        board_pkg::seg_t exp;
        repeat (cycles) @(posedge clk);
        #5;
        for (int k = 0; k < board_pkg::w_digit; k++)
        begin
            exp = static_image (value [4 * k +: 4]);
            assert (hex_all [k] === exp)
            else
            begin
                $display ("Mismatch hex%0d: got %h, expected %h", k, hex_all [k], exp);
                abort_run ();
            end
        end
    endtask

    //----------------------------------------------------------------------
    // Reference model and microphone model
    //----------------------------------------------------------------------

    assign tick_due = (edge_n > 0) && (edge_n % board_pkg::slow_tick_cycles == 0);

    always @(posedge clk or posedge rst)
        if (rst)
        begin
            edge_n      <= 0;
            model_ticks <= 0;
            model_cnt   <= '0;
        end
        else
        begin
            edge_n      <= edge_n + 1;
            model_ticks <= model_ticks + int'(tick_due);
            if (! key_n [0])
                model_cnt <= '0;                          // Clear first
            else if (! key_n [1])
                model_cnt <= board_pkg::count_t'(sw);     // Then load
            else if (tick_due && sw [0])
                model_cnt <= model_cnt + 1'b1;
        end

    // Data leaves on falling sck from one bit after ws falls
    always @(negedge mic_sck)
    begin
        #2;
        if (mic_bit < board_pkg::w_mic)
        begin
            mic_sd  = mic_word [board_pkg::w_mic - 1 - mic_bit];  // MSB first
            mic_bit = mic_bit + 1;
            if (mic_bit == board_pkg::w_mic)
                mic_words.push_back (mic_word);
        end
        if (ws_prev && ! mic_ws)
        begin
            mic_word = board_pkg::mic_t'(random_bits (board_pkg::w_mic));
            mic_bit  = 0;
        end
        ws_prev = mic_ws;
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------

    initial
    begin
        int                mark;
        logic [31:0]       rnd;
        board_pkg::count_t exp;

        rst   = 1'b1;
        key_n = '1;
        sw    = '0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;

        for (int k = 0; k < board_pkg::w_digit; k++)
        begin
            assert (hex_all [k] === '1)
            else
            begin
                $display ("Mismatch hex%0d: got %h, expected %h", k, hex_all [k], 8'hff);
                abort_run ();
            end
        end
        check_led ();

        // Left channel strap and idle I2S clocks
        assert (mic_lr === 1'b0 && mic_ws === 1'b0 && mic_sck === 1'b0)
        else
        begin
            $display ("Mismatch mic_lr mic_ws mic_sck: got %h %h %h, expected 0 0 0",
                      mic_lr, mic_ws, mic_sck);
            abort_run ();
        end

        check_display ('0, frame_cycles);  // Exactly one scan pass

        // Counting over 12 slow ticks
        @(posedge clk);
        #2 sw = 9'h001;
        repeat (12)
        begin
            mark = model_ticks;
            wait (model_ticks != mark);
            @(posedge clk);              // led follows one clock later
            #5;
            check_led ();
        end

        // Load, clear, and both keys together
        for (int i = 0; i < n_pulses; i++)
        begin
            @(posedge clk);
            #2;
            rnd = random_bits (board_pkg::w_sw);
            sw  = rnd [board_pkg::w_sw - 1:0];
            if (i == 2)
                key_n = 2'b10;           // Clear
            else if (i == 4)
                key_n = 2'b00;           // Both keys pressed so clear wins
            else
                key_n = 2'b01;           // Load
            @(posedge clk);
            #2;
            key_n = '1;
            sw    = '0;                  // Counting off and counter shown
            check_display (model_cnt, frame_cycles + settle_cycles);
            check_led ();
        end

        // Microphone frames on the displays
        @(posedge clk);
        #2 sw = 9'h002;
        repeat (n_mic_frames)
        begin
            mark = mic_words.size ();
            wait (mic_words.size () != mark);
            check_display (mic_words [$], frame_cycles + settle_cycles);
        end

        // Source switch right after a fresh capture
        repeat (n_toggles)
        begin
            mark = mic_words.size ();
            wait (mic_words.size () != mark);
            repeat (settle_cycles) @(posedge clk);
            #2;
            sw [1] = ~ sw [1];
            exp    = sw [1] ? mic_words [$] : model_cnt;
            check_display (exp, frame_cycles + settle_cycles);
        end

        $display ("Test completed successfully");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display ("Watchdog expired before all tests finished");
        abort_run ();
    end

endmodule

// File: board_top_asserts.sv
`timescale 1ns/1ps

module board_top_asserts
(
    input logic              clk,
    input logic              rst,
    input logic              slow_tick,
    input board_pkg::digit_t digit,      // Scanned select
    input board_pkg::seg_t   hex0,
    input board_pkg::seg_t   hex1,
    input board_pkg::seg_t   hex2,
    input board_pkg::seg_t   hex3,
    input board_pkg::seg_t   hex4,
    input board_pkg::seg_t   hex5,
    input logic              mic_ws,
    input logic              mic_sck
);

    board_pkg::seg_t hex_all [board_pkg::w_digit];

    assign hex_all [0] = hex0;
    assign hex_all [1] = hex1;
    assign hex_all [2] = hex2;
    assign hex_all [3] = hex3;
    assign hex_all [4] = hex4;
    assign hex_all [5] = hex5;

    //----------------------------------------------------------------------
    // Scan and latch
    //----------------------------------------------------------------------

    // Zero only before the first scan step
    digit_one_hot: assert property (@(posedge clk) disable iff (rst)
        $past (digit) != '0 |-> $onehot (digit))
        else $error ("digit select is not one-hot while scanning");

    for (genvar k = 0; k < board_pkg::w_digit; k++)
    begin : g_hex_hold
        hex_hold: assert property (@(posedge clk) disable iff (rst)
            ! $past (digit [k]) |-> $stable (hex_all [k]))  // Loads only after a select
            else $error ("hex%0d changed while its digit was not selected", k);
    end

    //----------------------------------------------------------------------
    // I2S and tick
    //----------------------------------------------------------------------

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
        $changed (mic_ws) |-> $fell (mic_sck))
        else $error ("mic_ws changed away from a falling mic_sck");

    single_tick: assert property (@(posedge clk) disable iff (rst)
        slow_tick |=> ! slow_tick)
        else $error ("slow_tick stayed high for two clocks");

endmodule

bind board_top board_top_asserts i_board_top_asserts
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .slow_tick ( slow_tick ),
    .digit     ( digit     ),
    .hex0      ( hex0      ),
    .hex1      ( hex1      ),
    .hex2      ( hex2      ),
    .hex3      ( hex3      ),
    .hex4      ( hex4      ),
    .hex5      ( hex5      ),
    .mic_ws    ( mic_ws    ),
    .mic_sck   ( mic_sck   )
);

// File: board_top.sv
`timescale 1ns/1ps

module board_top
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic [board_pkg::w_key - 1:0]  key_n,    // Push buttons, active low
    input  logic [board_pkg::w_sw  - 1:0]  sw,
    output logic [board_pkg::w_led - 1:0]  led,

    output board_pkg::seg_t                hex0,     // Static displays, active low
    output board_pkg::seg_t                hex1,
    output board_pkg::seg_t                hex2,
    output board_pkg::seg_t                hex3,
    output board_pkg::seg_t                hex4,
    output board_pkg::seg_t                hex5,

    output logic                           mic_lr,   // INMP441 pins
    output logic                           mic_ws,
    output logic                           mic_sck,
    input  logic                           mic_sd
);

    //--------------------------------------------------------------------

    logic              slow_tick;
    board_pkg::mic_t   mic;
    board_pkg::seg_t   abcdefgh;  // Scanned segment bus
    board_pkg::digit_t digit;

    //--------------------------------------------------------------------

    slow_tick_gen i_slow_tick_gen
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .slow_tick ( slow_tick )
    );

    lab_core i_lab_core
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .slow_tick ( slow_tick ),
        .key       ( ~ key_n   ),  // Pressed reads as 1
        .sw        ( sw        ),
        .mic       ( mic       ),
        .led       ( led       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     )
    );

    // Scanned bus to six steady displays
    hex_sticky_latch i_hex_sticky_latch
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .hex0      ( hex0      ),
        .hex1      ( hex1      ),
        .hex2      ( hex2      ),
        .hex3      ( hex3      ),
        .hex4      ( hex4      ),
        .hex5      ( hex5      )
    );

    mic_i2s_receiver i_microphone
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .lr        ( mic_lr    ),
        .ws        ( mic_ws    ),
        .sck       ( mic_sck   ),
        .sd        ( mic_sd    ),
        .value     ( mic       )
    );

endmodule

// File: mic_i2s_receiver.sv
`timescale 1ns/1ps

module mic_i2s_receiver
(
    input  logic            clk,
    input  logic            rst,
    output logic            lr,     // Channel select strap
    output logic            ws,     // Word select, low for left
    output logic            sck,    // Bit clock
    input  logic            sd,     // Serial data from the microphone
    output board_pkg::mic_t value   // Latest left sample
);

    typedef logic [$clog2(board_pkg::sck_half_cycles)   - 1:0] half_cnt_t;
    typedef logic [$clog2(board_pkg::mic_bits_per_half) - 1:0] bit_cnt_t;
    typedef logic [$clog2(board_pkg::w_mic)             - 1:0] smp_cnt_t;

    half_cnt_t             half_cnt;    // Clocks in the current sck half
    bit_cnt_t              bit_cnt;     // sck periods in the current ws half
    smp_cnt_t              smp_cnt;     // Data bits taken so far
    board_pkg::mic_state_t state;
    board_pkg::mic_t       shreg;       // Sample being assembled
    logic                  load_value;  // Copy shreg out next clock

    logic sck_edge;  // sck toggles on this clock
    logic sck_rise;
    logic sck_fall;
    logic ws_edge;   // ws toggles on this clock
    logic ws_rise;
    logic ws_fall;

    assign lr = 1'b0;  // Left channel

    //--------------------------------------------------------------------
    // Bit clock and word select
    //--------------------------------------------------------------------

    assign sck_edge = (half_cnt == half_cnt_t'(board_pkg::sck_half_cycles - 1));
    assign sck_rise = sck_edge & ~ sck;
    assign sck_fall = sck_edge &   sck;

    assign ws_edge  = sck_fall & (bit_cnt == bit_cnt_t'(board_pkg::mic_bits_per_half - 1));
    assign ws_rise  = ws_edge & ~ ws;
    assign ws_fall  = ws_edge &   ws;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            half_cnt <= '0;
            sck      <= 1'b0;
        end
        else if (sck_edge)
        begin
            half_cnt <= '0;
            sck      <= ~ sck;
        end
        else
            half_cnt <= half_cnt + 1'b1;

    // ws moves together with a falling sck
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (ws_edge)
        begin
            bit_cnt <= '0;
            ws      <= ~ ws;
        end
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;

    //--------------------------------------------------------------------
    // Capture FSM
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            state      <= board_pkg::idle;
            smp_cnt    <= '0;
            load_value <= 1'b0;
        end
        else
        begin
            load_value <= 1'b0;

            case (state)
            board_pkg::idle:
                if (ws_rise)
                    state <= board_pkg::wait_ws;   // Right half started

            board_pkg::wait_ws:
                if (ws_fall)
                    state <= board_pkg::skip;      // Left half starts

            board_pkg::skip:
                if (sck_rise)
                begin
                    state   <= board_pkg::shift;   // Dead bit passed
                    smp_cnt <= '0;
                end

            board_pkg::shift:
                if (sck_rise)
                begin
                    smp_cnt <= smp_cnt + 1'b1;

                    if (smp_cnt == smp_cnt_t'(board_pkg::w_mic - 1))
                    begin
                        state      <= board_pkg::idle;  // LSB taken
                        load_value <= 1'b1;
                    end
                end

            default:
                state <= board_pkg::idle;
            endcase
        end

    // MSB arrives first
    always_ff @ (posedge clk)
        if (state == board_pkg::shift && sck_rise)
            shreg <= { shreg [board_pkg::w_mic - 2:0], sd };

    always_ff @ (posedge clk or posedge rst)
        if (rst)
            value <= '0;
        else if (load_value)
            value <= shreg;

endmodule

// File: hex_sticky_latch.sv
`timescale 1ns/1ps

module hex_sticky_latch
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::seg_t   abcdefgh,  // Scanned, active high
    input  board_pkg::digit_t digit,     // One-hot select
    output board_pkg::seg_t   hex0,      // Static, active low
    output board_pkg::seg_t   hex1,
    output board_pkg::seg_t   hex2,
    output board_pkg::seg_t   hex3,
    output board_pkg::seg_t   hex4,
    output board_pkg::seg_t   hex5
);

    board_pkg::seg_t hgfedcba;  // Bit order of the static displays

    // Segment a moves from the top bit to bit 0
    always_comb
    begin
        for (int i = 0; i < $bits (board_pkg::seg_t); i++)
            hgfedcba [i] = abcdefgh [$bits (board_pkg::seg_t) - 1 - i];
    end

    // Each display keeps its last image between scan visits
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            { hex0, hex1, hex2, hex3, hex4, hex5 } <= '1;  // All blank
        end
        else
        begin
            if (digit [0]) hex0 <= ~ hgfedcba;
            if (digit [1]) hex1 <= ~ hgfedcba;
            if (digit [2]) hex2 <= ~ hgfedcba;
            if (digit [3]) hex3 <= ~ hgfedcba;
            if (digit [4]) hex4 <= ~ hgfedcba;
            if (digit [5]) hex5 <= ~ hgfedcba;
        end

endmodule

// File: lab_core.sv
`timescale 1ns/1ps

module lab_core
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           slow_tick,  // One clock enable pulse

    input  logic [board_pkg::w_key - 1:0]  key,        // Active high
    input  logic [board_pkg::w_sw  - 1:0]  sw,

    input  board_pkg::mic_t                mic,        // Latest left sample

    output logic [board_pkg::w_led - 1:0]  led,

    output board_pkg::seg_t                abcdefgh,
    output board_pkg::digit_t              digit
);

    //--------------------------------------------------------------------
    // Control decode
    //--------------------------------------------------------------------

    logic clear;      // key 0
    logic load;       // key 1
    logic count_en;   // sw 0
    logic show_mic;   // sw 1

    assign clear    = key [0];
    assign load     = key [1];
    assign count_en = sw  [0] & slow_tick;  // Only on tick edges
    assign show_mic = sw  [1];

    //--------------------------------------------------------------------
    // Counter
    //--------------------------------------------------------------------

    board_pkg::count_t cnt;

    // Clear beats load, load beats counting
    always_ff @ (posedge clk or posedge rst)
        if (rst)
            cnt <= '0;
        else if (clear)
            cnt <= '0;
        else if (load)
            cnt <= board_pkg::count_t'(sw);  // Zero extended
        else if (count_en)
            cnt <= cnt + 1'b1;

    //--------------------------------------------------------------------
    // LED drive
    //--------------------------------------------------------------------

    // Low bits of the counter, one clock behind it
    always_ff @ (posedge clk or posedge rst)
        if (rst)
            led <= '0;
        else
            led <= cnt [board_pkg::w_led - 1:0];

    //--------------------------------------------------------------------
    // Display source and scan
    //--------------------------------------------------------------------

    board_pkg::count_t shown;  // Value on the six digits

    assign shown = show_mic ? board_pkg::count_t'(mic) : cnt;

    display_scan i_display_scan
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .value    ( shown    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// File: display_scan.sv
`timescale 1ns/1ps

module display_scan
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::count_t value,
    output board_pkg::seg_t   abcdefgh,
    output board_pkg::digit_t digit
);

    typedef logic [$clog2(board_pkg::scan_cycles) - 1:0] dwell_t;
    typedef logic [$clog2(board_pkg::w_digit)     - 1:0] pos_t;

    dwell_t          dwell;   // Clocks spent on the current digit
    pos_t            pos;     // Index of the digit being driven
    logic [3:0]      nibble;  // Hex value of that digit
    board_pkg::seg_t seg;     // Its decoded pattern

    //--------------------------------------------------------------------
    // Hex to segment decode, active high, point always off
    //--------------------------------------------------------------------

    function automatic board_pkg::seg_t hex_to_seg (input logic [3:0] h);
        board_pkg::seg_t s;
        case (h)                 //    abcdefgh
            4'h0:    s = 8'b1111_1100;
            4'h1:    s = 8'b0110_0000;
            4'h2:    s = 8'b1101_1010;
            4'h3:    s = 8'b1111_0010;
            4'h4:    s = 8'b0110_0110;
            4'h5:    s = 8'b1011_0110;
            4'h6:    s = 8'b1011_1110;
            4'h7:    s = 8'b1110_0000;
            4'h8:    s = 8'b1111_1110;
            4'h9:    s = 8'b1111_0110;
            4'ha:    s = 8'b1110_1110;
            4'hb:    s = 8'b0011_1110;  // Lower case b
            4'hc:    s = 8'b1001_1100;
            4'hd:    s = 8'b0111_1010;  // Lower case d
            4'he:    s = 8'b1001_1110;
            default: s = 8'b1000_1110;  // F
        endcase
        return s;
    endfunction

    //--------------------------------------------------------------------
    // Dwell counter and digit position
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            dwell <= '0;
            pos   <= '0;
        end
        else if (dwell == dwell_t'(board_pkg::scan_cycles - 1))
        begin
            dwell <= '0;
            pos   <= (pos == pos_t'(board_pkg::w_digit - 1)) ? '0 : pos + 1'b1;  // Wrap
        end
        else
            dwell <= dwell + 1'b1;

    assign nibble = value [4 * pos +: 4];  // Nibble k sits at bits 4k+3..4k
    assign seg    = hex_to_seg (nibble);

    // Segments and select leave on the same edge
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            digit    <= '0;
            abcdefgh <= '0;
        end
        else
        begin
            digit    <= board_pkg::digit_t'(1) << pos;
            abcdefgh <= seg;
        end

endmodule

// File: slow_tick_gen.sv
`timescale 1ns/1ps

module slow_tick_gen
(
    input  logic clk,
    input  logic rst,
    output logic slow_tick
);

    typedef logic [$clog2(board_pkg::slow_tick_cycles) - 1:0] tick_cnt_t;

    localparam tick_cnt_t reload = tick_cnt_t'(board_pkg::slow_tick_cycles - 1);

    tick_cnt_t cnt;  // Clocks left until the next tick

    // Down counter, one registered pulse per wrap
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            cnt       <= reload;
            slow_tick <= 1'b0;
        end
        else
        begin
            slow_tick <= (cnt == '0);                    // Pulse lasts a single clock
            cnt       <= (cnt == '0) ? reload : cnt - 1'b1;
        end

endmodule

// File: board_pkg.sv
package board_pkg;

    //--------------------------------------------------------------------
    // Board and timing constants
    //--------------------------------------------------------------------

    localparam int clk_mhz           = 50;            // Board oscillator
    localparam int w_key             = 2;             // Push buttons
    localparam int w_sw              = 9;             // Lab switches
    localparam int w_led             = 10;            // Red LEDs
    localparam int w_digit           = 6;             // Seven-segment digits

    localparam int slow_tick_cycles  = clk_mhz * 100; // 100 us between ticks
    localparam int scan_cycles       = 16;            // Dwell per scanned digit

    localparam int sck_half_cycles   = 4;             // I2S bit clock half period
    localparam int mic_bits_per_half = 32;            // sck periods per ws half
    localparam int w_mic             = 24;            // INMP441 sample width

    //--------------------------------------------------------------------
    // Vector types
    //--------------------------------------------------------------------

    typedef logic [7:0]           seg_t;    // a..g at bits 7..1, h (point) at bit 0
    typedef logic [w_digit - 1:0] digit_t;  // One-hot digit select
    typedef logic [w_mic   - 1:0] mic_t;    // Signed sample, MSB first on the wire
    typedef logic [23:0]          count_t;  // Lab counter, six hex nibbles

    // Receiver phases within one I2S frame
    typedef enum logic [1:0]
    {
        wait_ws,  // Waiting for ws to fall, start of left half
        skip,     // Dead bit after the ws edge
        shift,    // Sampling data bits
        idle      // Rest of frame, waiting for ws to rise
    }
    mic_state_t;

endpackage
